/* sim.f */
cp0_reg_pkg.sv
exc_pkg.sv
exc_prioritizer.sv
cp0_regfile.sv
tlb_random.sv
cp0_top.sv
cp0_assertions.sv
cp0_checker.sv
tb_cp0.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := tb_cp0
FILELIST  := sim.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* tb_cp0.sv */
module tb_cp0;

	import cp0_reg_pkg::*;
	import exc_pkg::*;

	localparam int tlb_entries = 16;
	localparam int page_bits   = 12;

	typedef enum {op_write, op_read, op_rand, op_raise, op_hold, op_eret, op_idle} op_t;

	typedef struct {
		op_t         op;
		reg_addr_t   rg;
		logic [31:0] data;
		exc_req_t    req;
		logic [31:0] epc;
		logic [31:0] bva;
		logic [31:0] exp;
		logic        lvl;
		logic        um;
		int          takes;
	} row_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        write_en;
	reg_addr_t   wreg;
	logic [31:0] wdata;
	reg_addr_t   rreg;
	logic [31:0] rdata;
	exc_req_t    exc_req;
	logic [31:0] epc_in;
	logic [31:0] badvaddr_in;
	logic        eret;
	logic        exc_taken;
	logic        user_mode;
	logic        exc_level;
	logic [31:0] epc_out;
	logic [31:0] random_out;

	logic        check_en;
	int          row_idx;
	logic        chk_rdata;
	logic        chk_rand;
	logic        chk_epc;
	logic [31:0] exp_rdata;
	logic        exp_level;
	logic        exp_um;
	int          exp_takes;
	int          errors;
	logic        timed_out;

	row_t rows[$];
	int   take_total;

	always #4 clk = ~clk;

	cp0_top #(
		.tlb_entries (tlb_entries),
		.page_bits   (page_bits)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.write_en    (write_en),
		.wreg        (wreg),
		.wdata       (wdata),
		.rreg        (rreg),
		.rdata       (rdata),
		.exc_req     (exc_req),
		.epc_in      (epc_in),
		.badvaddr_in (badvaddr_in),
		.eret        (eret),
		.exc_taken   (exc_taken),
		.user_mode   (user_mode),
		.exc_level   (exc_level),
		.epc_out     (epc_out),
		.random_out  (random_out)
	);

	cp0_checker #(
		.tlb_entries (tlb_entries)
	) i_chk (
		.clk        (clk),
		.reset      (reset),
		.check_en   (check_en),
		.row_idx    (row_idx),
		.chk_rdata  (chk_rdata),
		.chk_rand   (chk_rand),
		.chk_epc    (chk_epc),
		.rdata      (rdata),
		.exc_taken  (exc_taken),
		.exc_level  (exc_level),
		.user_mode  (user_mode),
		.epc_out    (epc_out),
		.random_out (random_out),
		.exp_rdata  (exp_rdata),
		.exp_level  (exp_level),
		.exp_um     (exp_um),
		.exp_takes  (exp_takes),
		.errors     (errors)
	);

	task automatic add_row(input op_t op, input reg_addr_t rg, input logic [31:0] data,
			input exc_req_t req, input logic [31:0] epc, input logic [31:0] bva,
			input logic [31:0] exp, input logic lvl, input logic um);
		row_t r;
		r.op = op;
		r.rg = rg;
		r.data = data;
		r.req = req;
		r.epc = epc;
		r.bva = bva;
		r.exp = exp;
		r.lvl = lvl;
		r.um = um;
		if (op == op_raise) begin
			take_total++;
		end
		r.takes = take_total;
		rows.push_back(r);
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	task automatic build_table();
		logic [31:0] d0, d1, d2, d3, e1, e2, e3, e4, b1, b2, eh1;
		d0 = $urandom;
		d1 = $urandom;
		d2 = $urandom;
		d3 = $urandom;
		e1 = $urandom;
		e2 = $urandom;
		e3 = $urandom;
		e4 = $urandom;
		b1 = $urandom;
		b2 = $urandom;
		// vpn from the fault address, offset from the earlier write.
		eh1 = {b1[31:page_bits], d3[page_bits-1:0]};
		take_total = 0;
		add_row(op_read, reg_status, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_cause, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_epc, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_entryhi, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_rand, reg_random, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_write, 5'd20, d0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, 5'd20, 0, 0, 0, 0, d0, 0, 0);
		add_row(op_write, reg_entrylo0, d1, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_entrylo0, 0, 0, 0, 0, d1, 0, 0);
		add_row(op_write, reg_badvaddr, d2, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_badvaddr, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_write, reg_random, d2, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_rand, reg_random, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_write, reg_entryhi, d3, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_entryhi, 0, 0, 0, 0, d3, 0, 0);
		add_row(op_write, reg_status, 32'h10, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_read, reg_status, 0, 0, 0, 0, 32'h10, 0, 1);
		// ovf outranks ri, sys and tlbs.
		add_row(op_raise, 0, 0, 9'h11c, e1, 0, 32'h0, 0, 1);
		add_row(op_read, reg_cause, 0, 0, 0, 0, 32'd12 << 2, 1, 0);
		add_row(op_read, reg_epc, 0, 0, 0, 0, e1, 1, 0);
		add_row(op_read, reg_status, 0, 0, 0, 0, 32'h2, 1, 0);
		add_row(op_hold, 0, 0, 9'h001, e2, 0, 32'h0, 1, 0);
		add_row(op_read, reg_cause, 0, 0, 0, 0, 32'd12 << 2, 1, 0);
		add_row(op_read, reg_epc, 0, 0, 0, 0, e1, 1, 0);
		add_row(op_eret, 0, 0, 0, 0, 0, 32'h0, 1, 0);
		add_row(op_read, reg_status, 0, 0, 0, 0, 32'h0, 0, 0);
		add_row(op_raise, 0, 0, 9'h080, e3, b1, 32'h0, 0, 0);
		add_row(op_read, reg_cause, 0, 0, 0, 0, 32'd2 << 2, 1, 0);
		add_row(op_read, reg_badvaddr, 0, 0, 0, 0, b1, 1, 0);
		add_row(op_read, reg_entryhi, 0, 0, 0, 0, eh1, 1, 0);
		add_row(op_read, reg_epc, 0, 0, 0, 0, e3, 1, 0);
		add_row(op_eret, 0, 0, 0, 0, 0, 32'h0, 1, 0);
		// addrl beats tlbs, entryhi left alone.
		add_row(op_raise, 0, 0, 9'h140, e4, b2, 32'h0, 0, 0);
		add_row(op_read, reg_cause, 0, 0, 0, 0, 32'd4 << 2, 1, 0);
		add_row(op_read, reg_badvaddr, 0, 0, 0, 0, b2, 1, 0);
		add_row(op_read, reg_entryhi, 0, 0, 0, 0, eh1, 1, 0);
		add_row(op_read, reg_epc, 0, 0, 0, 0, e4, 1, 0);
		add_row(op_eret, 0, 0, 0, 0, 0, 32'h0, 1, 0);
		for (int i = 0; i < 20; i++) begin
			add_row(op_rand, reg_random, 0, 0, 0, 0, 32'h0, 0, 0);
		end
		add_row(op_idle, 0, 0, 0, 0, 0, 32'h0, 0, 0);
	endtask

	task automatic wait_taken(input int idx);
		int n;
		logic got;
		n = 0;
		got = 1'b0;
		while (!got && n < 20) begin
			@(negedge clk);
			check_en = 1'b0;
			got = exc_taken;
			n++;
		end
		if (!got) begin
			$display("row %0d: exc_taken never pulsed within 20 cycles", idx);
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_row(input int idx);
		row_t r;
		r = rows[idx];
		row_idx = idx;
		write_en = (r.op == op_write);
		wreg = r.rg;
		wdata = r.data;
		rreg = r.rg;
		eret = (r.op == op_eret);
		exc_req = (r.op == op_raise || r.op == op_hold) ? r.req : '0;
		epc_in = r.epc;
		badvaddr_in = r.bva;
		check_en = 1'b1;
		chk_rdata = (r.op == op_read);
		chk_rand = (r.op == op_rand);
		chk_epc = (r.op == op_read) && (r.rg == reg_epc);
		exp_rdata = r.exp;
		exp_level = r.lvl;
		exp_um = r.um;
		exp_takes = r.takes;
		if (r.op == op_raise) begin
			wait_taken(idx);
		end else if (r.op == op_hold) begin
			// ignored request is held a few cycles.
			repeat (3) begin
				@(negedge clk);
				check_en = 1'b0;
			end
		end else begin
			@(negedge clk);
		end
	endtask

	initial begin
		void'($urandom(32'h3f98_cfd2));
		reset = 1'b1;
		write_en = 1'b0;
		wreg = '0;
		wdata = '0;
		rreg = '0;
		exc_req = '0;
		epc_in = '0;
		badvaddr_in = '0;
		eret = 1'b0;
		check_en = 1'b0;
		row_idx = 0;
		chk_rdata = 1'b0;
		chk_rand = 1'b0;
		chk_epc = 1'b0;
		exp_rdata = '0;
		exp_level = 1'b0;
		exp_um = 1'b0;
		exp_takes = 0;
		timed_out = 1'b0;
		build_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			apply_row(i);
		end
		check_en = 1'b0;
		write_en = 1'b0;
		exc_req = '0;
		eret = 1'b0;
		@(negedge clk);
		i_chk.report();
		if (!timed_out && errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* cp0_checker.sv */
module cp0_checker #(
	parameter int tlb_entries = 16
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        check_en,
	input  int          row_idx,
	input  logic        chk_rdata,
	input  logic        chk_rand,
	input  logic        chk_epc,
	input  logic [31:0] rdata,
	input  logic        exc_taken,
	input  logic        exc_level,
	input  logic        user_mode,
	input  logic [31:0] epc_out,
	input  logic [31:0] random_out,
	input  logic [31:0] exp_rdata,
	input  logic        exp_level,
	input  logic        exp_um,
	input  int          exp_takes,
	output int          errors
);

	int          takes_seen = 0;
	int          rows_done = 0;
	int          row_errs;
	int          total;
	logic [31:0] rand_model;

	initial errors = 0;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("Mismatch at %0t: %s expected %08h actual %08h", $time, name, exp, act);
		row_errs++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			rand_model = tlb_entries - 1;
		end else begin
			total = takes_seen + int'(exc_taken);
			takes_seen = total;
			if (check_en) begin
				row_errs = 0;
				if (random_out !== rand_model) mismatch("random_out", rand_model, random_out);
				if (chk_rdata) begin
					if (rdata !== exp_rdata) mismatch("rdata", exp_rdata, rdata);
					if (exc_level !== exp_level) mismatch("exc_level", exp_level, exc_level);
					if (user_mode !== exp_um) mismatch("user_mode", exp_um, user_mode);
					if (total != exp_takes) mismatch("exc_taken count", exp_takes, total);
					if (chk_epc && epc_out !== exp_rdata) mismatch("epc_out", exp_rdata, epc_out);
				end
				if (chk_rand) begin
					if (rdata >= tlb_entries) begin
						$display("row %0d: random index %0d out of range", row_idx, rdata);
						row_errs++;
					end
					if (rdata !== rand_model) mismatch("random", rand_model, rdata);
				end
				errors += row_errs;
				rows_done++;
				$display("row %0d %s", row_idx, (row_errs == 0) ? "ok" : "failed");
			end
			// down one per cycle, wrapping to the top slot.
			rand_model = (rand_model == 0) ? tlb_entries - 1 : rand_model - 1;
		end
	end

	task automatic report();
		$display("rows checked %0d, errors %0d", rows_done, errors);
	endtask

endmodule

/* cp0_assertions.sv */
module cp0_assertions #(
	parameter int tlb_entries = 16
) (
	input logic       clk,
	input logic       reset,
	input logic       exc_taken,
	input logic       exc_level,
	input logic [7:0] rand_index
);

	// single cycle pulse.
	assert property (@(posedge clk) disable iff (reset) exc_taken |=> !exc_taken)
		else $error("exc_taken high for two cycles");

	// no commit while a handler was running.
	assert property (@(posedge clk) disable iff (reset) exc_taken |-> !$past(exc_level))
		else $error("exc_taken after exception level was set");

	assert property (@(posedge clk) disable iff (reset) rand_index < tlb_entries)
		else $error("random index out of range");

endmodule

bind cp0_regfile cp0_assertions #(
	.tlb_entries (16)
) i_assertions (
	.clk        (clk),
	.reset      (reset),
	.exc_taken  (exc_taken),
	.exc_level  (exc_level),
	.rand_index (rand_index)
);

/* cp0_top.sv */
module cp0_top #(
	parameter int tlb_entries = 16,
	parameter int page_bits   = 12
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   write_en,
	input  cp0_reg_pkg::reg_addr_t wreg,
	input  logic [31:0]            wdata,
	input  cp0_reg_pkg::reg_addr_t rreg,
	output logic [31:0]            rdata,
	input  exc_pkg::exc_req_t      exc_req,
	input  logic [31:0]            epc_in,
	input  logic [31:0]            badvaddr_in,
	input  logic                   eret,
	output logic                   exc_taken,
	output logic                   user_mode,
	output logic                   exc_level,
	output logic [31:0]            epc_out,
	output logic [31:0]            random_out
);

	logic               exc_valid;
	exc_pkg::exc_code_t exc_code;
	logic [7:0]         rand_index;

	exc_prioritizer i_prio (
		.exc_req   (exc_req),
		.exc_level (exc_level),
		.exc_valid (exc_valid),
		.exc_code  (exc_code)
	);

	cp0_regfile #(
		.page_bits (page_bits)
	) i_regfile (
		.clk         (clk),
		.reset       (reset),
		.write_en    (write_en),
		.wreg        (wreg),
		.rreg        (rreg),
		.wdata       (wdata),
		.eret        (eret),
		.exc_valid   (exc_valid),
		.exc_code    (exc_code),
		.epc_in      (epc_in),
		.badvaddr_in (badvaddr_in),
		.rand_index  (rand_index),
		.rdata       (rdata),
		.exc_taken   (exc_taken),
		.exc_level   (exc_level),
		.user_mode   (user_mode),
		.epc_out     (epc_out)
	);

	tlb_random #(
		.tlb_entries (tlb_entries)
	) i_random (
		.clk        (clk),
		.reset      (reset),
		.rand_index (rand_index)
	);

	assign random_out = {24'd0, rand_index};

endmodule

/* tlb_random.sv */
module tlb_random #(
	parameter int tlb_entries = 16
) (
	input  logic       clk,
	input  logic       reset,
	output logic [7:0] rand_index
);

	// highest slot, where the count starts and wraps to.
	localparam logic [7:0] top_slot = 8'(tlb_entries - 1);

	logic at_bottom;

	assign at_bottom = (rand_index == 8'd0);

	////////////////////////////////////////
	// down counter
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			rand_index <= top_slot;
		end else if (at_bottom) begin
			rand_index <= top_slot;
		end else begin
			rand_index <= rand_index - 8'd1;
		end
	end

endmodule

/* cp0_regfile.sv */
module cp0_regfile #(
	parameter int page_bits = 12
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  write_en,
	input  cp0_reg_pkg::reg_addr_t wreg,
	input  cp0_reg_pkg::reg_addr_t rreg,
	input  logic [31:0]           wdata,
	input  logic                  eret,
	input  logic                  exc_valid,
	input  exc_pkg::exc_code_t    exc_code,
	input  logic [31:0]           epc_in,
	input  logic [31:0]           badvaddr_in,
	input  logic [7:0]            rand_index,
	output logic [31:0]           rdata,
	output logic                  exc_taken,
	output logic                  exc_level,
	output logic                  user_mode,
	output logic [31:0]           epc_out
);

	import cp0_reg_pkg::*;
	import exc_pkg::*;

	logic [31:0] regs [32];

	cp0_word_t   status_q;
	cp0_word_t   status_nx;
	cp0_word_t   rd_word;
	logic        write_ok;
	logic        addr_class;
	logic        tlb_class;
	logic [31:0] cause_commit;
	logic [31:0] entryhi_commit;

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	always_comb begin
		rd_word.raw = regs[rreg];
		// random lives in the counter, not the bank.
		if (rreg == reg_random) begin
			rd_word.raw = {24'd0, rand_index};
		end
	end

	assign rdata = rd_word.raw;

	assign status_q.raw = regs[reg_status];
	assign exc_level    = status_q.status.exl;
	assign user_mode    = status_q.status.um;
	assign epc_out      = regs[reg_epc];

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	// random and badvaddr are read only to software.
	assign write_ok = write_en && (wreg != reg_random) && (wreg != reg_badvaddr);

	assign addr_class = exc_code inside {exc_addrl, exc_addrs, exc_tlbl, exc_tlbs};
	assign tlb_class  = exc_code inside {exc_tlbl, exc_tlbs};

	always_comb begin
		cause_commit = regs[reg_cause];
		cause_commit[cause_code_msb:cause_code_lsb] = exc_code;
	end

	// vpn from the faulting address, offset bits kept.
	assign entryhi_commit = {badvaddr_in[31:page_bits], regs[reg_entryhi][page_bits-1:0]};

	always_comb begin
		status_nx = status_q;
		if (exc_valid) begin
			status_nx.status.exl = 1'b1;
			status_nx.status.um  = 1'b0;
		end else begin
			if (write_en && wreg == reg_status) begin
				status_nx.raw = wdata;
			end
			if (eret) begin
				status_nx.status.exl = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// bank update
	////////////////////////////////////////

	// later assignments override the plain mtc0 write.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			exc_taken <= 1'b0;
		end else begin
			if (write_ok) begin
				regs[wreg] <= wdata;
			end
			regs[reg_status] <= status_nx.raw;
			if (exc_valid) begin
				regs[reg_cause] <= cause_commit;
				regs[reg_epc]   <= epc_in;
				if (addr_class) begin
					regs[reg_badvaddr] <= badvaddr_in;
				end
				if (tlb_class) begin
					regs[reg_entryhi] <= entryhi_commit;
				end
			end
			exc_taken <= exc_valid;
		end
	end

endmodule

/* exc_prioritizer.sv */
module exc_prioritizer (
	input  exc_pkg::exc_req_t  exc_req,
	input  logic               exc_level,
	output logic               exc_valid,
	output exc_pkg::exc_code_t exc_code
);

	import exc_pkg::*;

	logic any_req;

	assign any_req = |exc_req;

	// nothing new is taken while a handler runs.
	assign exc_valid = any_req && !exc_level;

	////////////////////////////////////////
	// fixed priority encode
	////////////////////////////////////////

	// walk from lowest priority up so the highest set line is left.
	always_comb begin
		exc_code = exc_ext;
		for (int i = num_exc - 1; i >= 0; i--) begin
			if (exc_req[i]) begin
				exc_code = exc_code_by_idx[i];
			end
		end
	end

endmodule

/* exc_pkg.sv */
package exc_pkg;

	typedef logic [4:0] exc_code_t;

	localparam exc_code_t exc_ext   = 5'd0;
	localparam exc_code_t exc_tlbl  = 5'd2;
	localparam exc_code_t exc_tlbs  = 5'd3;
	localparam exc_code_t exc_addrl = 5'd4;
	localparam exc_code_t exc_addrs = 5'd5;
	localparam exc_code_t exc_sys   = 5'd8;
	localparam exc_code_t exc_ri    = 5'd10;
	localparam exc_code_t exc_ovf   = 5'd12;
	localparam exc_code_t exc_tr    = 5'd13;

	// request lines, lower index wins.
	localparam int num_exc = 9;

	typedef logic [num_exc-1:0] exc_req_t;

	localparam int exc_idx_ext   = 0;
	localparam int exc_idx_tr    = 1;
	localparam int exc_idx_ovf   = 2;
	localparam int exc_idx_ri    = 3;
	localparam int exc_idx_sys   = 4;
	localparam int exc_idx_addrs = 5;
	localparam int exc_idx_addrl = 6;
	localparam int exc_idx_tlbl  = 7;
	localparam int exc_idx_tlbs  = 8;

	// code reported for each request line, in priority order.
	localparam exc_code_t exc_code_by_idx [num_exc] = '{
		exc_ext, exc_tr, exc_ovf, exc_ri, exc_sys,
		exc_addrs, exc_addrl, exc_tlbl, exc_tlbs
	};

endpackage

/* cp0_reg_pkg.sv */
package cp0_reg_pkg;

	////////////////////////////////////////
	// register numbers
	////////////////////////////////////////

	typedef logic [4:0] reg_addr_t;

	localparam reg_addr_t reg_random   = 5'd1;
	localparam reg_addr_t reg_entrylo0 = 5'd2;
	localparam reg_addr_t reg_badvaddr = 5'd8;
	localparam reg_addr_t reg_entryhi  = 5'd10;
	localparam reg_addr_t reg_status   = 5'd12;
	localparam reg_addr_t reg_cause    = 5'd13;
	localparam reg_addr_t reg_epc      = 5'd14;

	////////////////////////////////////////
	// field layouts
	////////////////////////////////////////

	// status, msb first.
	typedef struct packed {
		logic [26:0] reserved_hi;
		logic        um;
		logic [1:0]  reserved_mid;
		logic        exl;
		logic        reserved_lo;
	} status_fields_t;

	// one word, seen raw by mtc0/mfc0 or as status fields.
	typedef union packed {
		logic [31:0]    raw;
		status_fields_t status;
	} cp0_word_t;

	// exception code inside cause.
	localparam int cause_code_lsb = 2;
	localparam int cause_code_msb = 6;

endpackage
